//--- hw/hash_search_pkg.sv
`default_nettype none

package hash_search_pkg;

    localparam int unsigned UPSTREAM_BYPASS_BITS = 1;  // Upstream device sits in BYPASS
    localparam int unsigned KEY_BYTES = 12;
    localparam int unsigned SUFFIX_DIGITS = 7;
    localparam int unsigned MD5_BLOCK_BYTES = 64;
    localparam int unsigned MAX_MSG_BYTES = MD5_BLOCK_BYTES - 8;  // Room left for length field
    localparam int unsigned FILTER_ZERO_BITS = 8;
    localparam int unsigned RESULT_BITS = 129;  // Digest plus found flag

    typedef logic [7:0] byte_t;

    // First key character in the low byte
    typedef logic [8*KEY_BYTES-1:0] key_t;
    typedef logic [3:0] key_len_t;

    // Most significant digit in the low byte
    typedef logic [8*SUFFIX_DIGITS-1:0] suffix_ascii_t;
    typedef logic [2:0] suffix_len_t;

    typedef logic [31:0] word_t;

    // Byte 0 of the block in the low byte
    typedef logic [8*MD5_BLOCK_BYTES-1:0] md5_block_t;

    // First output byte in the top byte
    typedef logic [127:0] digest_t;

    typedef logic [RESULT_BITS-1:0] result_t;

endpackage

`default_nettype wire

//--- hw/tap_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tap_decoder import hash_search_pkg::*; (
    input  logic  tck,
    input  logic  reset,
    input  logic  tdi,
    input  logic  shift_dr,
    input  logic  update_dr,
    output logic  byte_valid,
    output byte_t byte_data
);

    logic [$clog2(UPSTREAM_BYPASS_BITS+1)-1:0] bypass_cnt;
    logic [2:0] bit_cnt;
    logic [6:0] shreg;  // First seven bits of the byte
    logic bypass_done;

    assign bypass_done = (bypass_cnt == UPSTREAM_BYPASS_BITS);

    always_ff @(posedge tck) begin
        if (reset) begin
            byte_valid <= 1'b0;
            bypass_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            byte_valid <= 1'b0;
            if (update_dr) begin  // New shift run starts over
                bypass_cnt <= '0;
                bit_cnt <= '0;
            end else if (shift_dr) begin
                if (!bypass_done) begin
                    bypass_cnt <= bypass_cnt + 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    byte_valid <= (bit_cnt == 3'd7);
                end
            end
        end
    end

    // LSB first, so bits enter at the top and move down
    always_ff @(posedge tck) begin
        if (shift_dr && bypass_done) begin
            shreg <= {tdi, shreg[6:1]};
            if (bit_cnt == 3'd7) begin
                byte_data <= {tdi, shreg};
            end
        end
    end

    assert property (@(posedge tck) disable iff (reset) byte_valid |=> !byte_valid);

endmodule

`default_nettype wire

//--- hw/line_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module line_decoder import hash_search_pkg::*; (
    input  logic     tck,
    input  logic     reset,
    input  logic     byte_valid,
    input  byte_t    byte_data,
    output logic     key_valid,
    output key_t     key_data,
    output key_len_t key_len
);

    logic is_newline;

    assign is_newline = (byte_data == 8'h0a);

    always_ff @(posedge tck) begin
        if (reset) begin
            key_valid <= 1'b0;
            key_len <= '0;
        end else if (byte_valid && !key_valid) begin  // Frozen once the line is complete
            if (is_newline) begin
                key_valid <= 1'b1;
            end else if (key_len < KEY_BYTES) begin
                key_len <= key_len + 1'b1;
            end
        end
    end

    // Key characters, only the first key_len bytes are meaningful
    always_ff @(posedge tck) begin
        if (byte_valid && !key_valid && !is_newline && key_len < KEY_BYTES) begin
            key_data[8*key_len +: 8] <= byte_data;
        end
    end

    assert property (@(posedge tck) disable iff (reset) key_len <= KEY_BYTES);

endmodule

`default_nettype wire

//--- hw/ascii_counter.sv
`timescale 1ns/1ps
`default_nettype none

module ascii_counter import hash_search_pkg::*; (
    input  logic          tck,
    input  logic          reset,
    input  logic          suffix_ready,
    output logic          suffix_valid,
    output suffix_ascii_t suffix_data,
    output suffix_len_t   suffix_len
);

    // BCD digits, least significant first
    logic [3:0] digit [SUFFIX_DIGITS];
    logic [3:0] digit_next [SUFFIX_DIGITS];
    suffix_len_t len_next;
    logic wrap;  // Carry out of the top digit

    always_comb begin
        logic carry;
        carry = 1'b1;
        for (int i = 0; i < SUFFIX_DIGITS; i++) begin
            if (carry && digit[i] == 4'd9) begin
                digit_next[i] = 4'd0;
            end else begin
                digit_next[i] = digit[i] + {3'b000, carry};
                carry = 1'b0;
            end
        end
        wrap = carry;

        // Grow when the carry lands above the current top digit
        len_next = suffix_len;
        for (int i = 0; i < SUFFIX_DIGITS; i++) begin
            if (i >= suffix_len && digit_next[i] != 4'd0) begin
                len_next = suffix_len_t'(i + 1);
            end
        end
    end

    always_ff @(posedge tck) begin
        if (reset) begin
            suffix_valid <= 1'b1;
            suffix_len <= suffix_len_t'(1);  // Start at "0"
            digit <= '{default: '0};
        end else if (suffix_valid && suffix_ready) begin
            if (wrap) begin
                suffix_valid <= 1'b0;  // All nines used up
            end else begin
                digit <= digit_next;
                suffix_len <= len_next;
            end
        end
    end

    // Reverse into ASCII, unused bytes stay zero
    always_comb begin
        suffix_data = '0;
        for (int i = 0; i < SUFFIX_DIGITS; i++) begin
            if (i < suffix_len) begin
                suffix_data[8*i +: 8] = {4'h3, digit[int'(suffix_len) - 1 - i]};
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/message_builder.sv
`timescale 1ns/1ps
`default_nettype none

module message_builder import hash_search_pkg::*; (
    input  logic          tck,
    input  logic          reset,
    input  logic          key_valid,
    input  key_t          key_data,
    input  key_len_t      key_len,
    input  logic          suffix_valid,
    input  suffix_ascii_t suffix_data,
    input  suffix_len_t   suffix_len,
    input  logic          block_ready,
    output logic          suffix_ready,
    output logic          block_valid,
    output md5_block_t    block_data
);

    logic [5:0] msg_len;  // Bytes
    key_t key_mask;
    md5_block_t block_next;

    // Only one block is held here at a time
    assign suffix_ready = key_valid && !block_valid;

    always_comb begin
        msg_len = 6'(key_len) + 6'(suffix_len);
        key_mask = ~({8*KEY_BYTES{1'b1}} << (8 * key_len));

        // Key, then suffix, then the 0x80 pad, zero fill up to the length field
        block_next = md5_block_t'(key_data & key_mask)
                   | (md5_block_t'(suffix_data) << (8 * key_len))
                   | (md5_block_t'(8'h80) << (8 * msg_len));

        // Bit length, little endian in bytes 56 to 63
        block_next = block_next | (md5_block_t'(msg_len) << (8 * MAX_MSG_BYTES + 3));
    end

    always_ff @(posedge tck) begin
        if (reset) begin
            block_valid <= 1'b0;
        end else if (suffix_valid && suffix_ready) begin
            block_valid <= 1'b1;
        end else if (block_valid && block_ready) begin
            block_valid <= 1'b0;
        end
    end

    always_ff @(posedge tck) begin
        if (suffix_valid && suffix_ready) begin
            block_data <= block_next;  // Held until the core takes it
        end
    end

    // Key and suffix come from different blocks, together they must fit
    assert property (@(posedge tck) disable iff (reset)
        suffix_valid && suffix_ready |-> msg_len <= MAX_MSG_BYTES);

endmodule

`default_nettype wire

//--- hw/md5_core.sv
`timescale 1ns/1ps
`default_nettype none

module md5_core import hash_search_pkg::*; (
    input  logic       tck,
    input  logic       reset,
    input  logic       block_valid,
    input  md5_block_t block_data,
    output logic       block_ready,
    output logic       digest_valid,
    output digest_t    digest_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_round,
        st_finish
    } state_t;

    state_t state;
    logic [5:0] round_cnt;
    md5_block_t msg;
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    word_t iv [4];
    word_t k_table [64];
    logic [4:0] s_table [16];
    word_t f_val;
    word_t m_word;
    word_t rot_in;
    word_t b_next;
    logic [3:0] m_idx;
    logic [4:0] shift;

    function automatic word_t bswap(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign iv = '{32'h67452301, 32'hefcdab89, 32'h98badcfe, 32'h10325476};

    // Integer part of abs(sin(i+1)) * 2^32
    assign k_table = '{
        32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
        32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
        32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
        32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
        32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
        32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
        32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
        32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
        32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
        32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
        32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
        32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
        32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
        32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
        32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
        32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
    };

    // Rotate amounts, four per quarter
    assign s_table = '{
        5'd7, 5'd12, 5'd17, 5'd22,
        5'd5, 5'd9, 5'd14, 5'd20,
        5'd4, 5'd11, 5'd16, 5'd23,
        5'd6, 5'd10, 5'd15, 5'd21
    };

    always_comb begin
        case (round_cnt[5:4])
            2'd0: begin
                f_val = (b & c) | (~b & d);
                m_idx = round_cnt[3:0];
            end
            2'd1: begin
                f_val = (d & b) | (~d & c);
                m_idx = 4'(5 * round_cnt + 1);
            end
            2'd2: begin
                f_val = b ^ c ^ d;
                m_idx = 4'(3 * round_cnt + 5);
            end
            default: begin
                f_val = c ^ (b | ~d);
                m_idx = 4'(7 * round_cnt);
            end
        endcase
        m_word = msg[32*m_idx +: 32];  // Words are little endian already
        shift = s_table[{round_cnt[5:4], round_cnt[1:0]}];
        rot_in = a + f_val + k_table[round_cnt] + m_word;
        b_next = b + ((rot_in << shift) | (rot_in >> (32 - shift)));
    end

    always_ff @(posedge tck) begin
        if (reset) begin
            state <= st_idle;
            round_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (block_valid) begin
                        state <= st_round;
                        round_cnt <= '0;
                    end
                end
                st_round: begin
                    round_cnt <= round_cnt + 1'b1;
                    if (round_cnt == 6'd63) begin
                        state <= st_finish;
                    end
                end
                default: state <= st_idle;  // Digest shown for one cycle
            endcase
        end
    end

    always_ff @(posedge tck) begin
        if (state == st_idle && block_valid) begin
            msg <= block_data;
            a <= iv[0];
            b <= iv[1];
            c <= iv[2];
            d <= iv[3];
        end else if (state == st_round) begin
            a <= d;
            b <= b_next;
            c <= b;
            d <= c;
        end
    end

    assign block_ready = (state == st_idle);
    assign digest_valid = (state == st_finish);
    assign digest_data = {bswap(a + iv[0]), bswap(b + iv[1]), bswap(c + iv[2]), bswap(d + iv[3])};

    assert property (@(posedge tck) disable iff (reset)
        block_valid && block_ready |-> ##1 (!digest_valid) [*64] ##1 digest_valid);

endmodule

`default_nettype wire

//--- hw/hash_filter.sv
`timescale 1ns/1ps
`default_nettype none

module hash_filter import hash_search_pkg::*; (
    input  logic    tck,
    input  logic    reset,
    input  logic    digest_valid,
    input  digest_t digest_data,
    output logic    found,
    output digest_t found_digest
);

    logic hit;

    // Leading bits of the first output byte must be zero
    assign hit = digest_valid && (digest_data[$bits(digest_t)-1 -: FILTER_ZERO_BITS] == '0);

    always_ff @(posedge tck) begin
        if (reset) begin
            found <= 1'b0;
            found_digest <= '0;  // Reads back as zero until a match
        end else if (hit && !found) begin
            found <= 1'b1;
            found_digest <= digest_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/tap_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module tap_encoder import hash_search_pkg::*; (
    input  logic    tck,
    input  logic    reset,
    input  logic    found,
    input  digest_t found_digest,
    input  logic    capture_dr,
    input  logic    shift_dr,
    output logic    tdo
);

    result_t shreg;

    always_ff @(posedge tck) begin
        if (reset) begin
            shreg <= '0;
        end else if (capture_dr) begin
            shreg <= {found_digest, found};  // Flag goes out first
        end else if (shift_dr) begin
            shreg <= {1'b0, shreg[RESULT_BITS-1:1]};
        end
    end

    assign tdo = shreg[0];

endmodule

`default_nettype wire

//--- hw/user_logic.sv
`timescale 1ns/1ps
`default_nettype none

module user_logic import hash_search_pkg::*; (
    input  logic tck,
    input  logic tms,
    input  logic tdi,
    input  logic test_logic_reset,
    input  logic ir_is_user,
    input  logic run_test_idle,
    input  logic capture_dr,
    input  logic shift_dr,
    input  logic update_dr,
    output logic tdo
);

    logic reset;
    logic byte_valid;
    byte_t byte_data;
    logic key_valid;
    key_t key_data;
    key_len_t key_len;
    logic suffix_valid;
    logic suffix_ready;
    suffix_ascii_t suffix_data;
    suffix_len_t suffix_len;
    logic block_valid;
    logic block_ready;
    md5_block_t block_data;
    logic digest_valid;
    digest_t digest_data;
    logic found;
    digest_t found_digest;
    logic unused_pins;

    // Leaving the user instruction clears the search
    assign reset = test_logic_reset || !ir_is_user;

    // Kept for TAP pin compatibility only
    assign unused_pins = tms ^ run_test_idle;

    tap_decoder tap_decoder_i (
        .tck        (tck),
        .reset      (reset),
        .tdi        (tdi),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    line_decoder line_decoder_i (
        .tck        (tck),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .key_valid  (key_valid),
        .key_data   (key_data),
        .key_len    (key_len)
    );

    ascii_counter ascii_counter_i (
        .tck          (tck),
        .reset        (reset),
        .suffix_ready (suffix_ready),
        .suffix_valid (suffix_valid),
        .suffix_data  (suffix_data),
        .suffix_len   (suffix_len)
    );

    message_builder message_builder_i (
        .tck          (tck),
        .reset        (reset),
        .key_valid    (key_valid),
        .key_data     (key_data),
        .key_len      (key_len),
        .suffix_valid (suffix_valid),
        .suffix_data  (suffix_data),
        .suffix_len   (suffix_len),
        .block_ready  (block_ready),
        .suffix_ready (suffix_ready),
        .block_valid  (block_valid),
        .block_data   (block_data)
    );

    md5_core md5_core_i (
        .tck          (tck),
        .reset        (reset),
        .block_valid  (block_valid),
        .block_data   (block_data),
        .block_ready  (block_ready),
        .digest_valid (digest_valid),
        .digest_data  (digest_data)
    );

    hash_filter hash_filter_i (
        .tck          (tck),
        .reset        (reset),
        .digest_valid (digest_valid),
        .digest_data  (digest_data),
        .found        (found),
        .found_digest (found_digest)
    );

    tap_encoder tap_encoder_i (
        .tck          (tck),
        .reset        (reset),
        .found        (found),
        .found_digest (found_digest),
        .capture_dr   (capture_dr),
        .shift_dr     (shift_dr),
        .tdo          (tdo)
    );

endmodule

`default_nettype wire

//--- verif/user_logic_checker.sv
`timescale 1ns/1ps
`default_nettype none

module user_logic_checker import hash_search_pkg::*; (
    input  logic    tck,
    input  logic    capture_dr,
    input  logic    shift_dr,
    input  logic    tdo,
    input  logic    test_active,
    input  logic    expect_match,
    input  int      test_id,
    input  digest_t expect_digest,
    output logic    read_found,
    output int      tests_passed,
    output int      tests_failed
);

    result_t shreg;
    int nbits = RESULT_BITS;  // Idle until the first capture
    int reads = 0;
    int found_reads = 0;
    int errors = 0;
    logic test_open = 1'b0;
    digest_t first_digest;

    initial begin
        read_found = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
    end

    task automatic check_read(input result_t value);
        digest_t digest;
        logic flag;
        digest = value[RESULT_BITS-1:1];
        flag = value[0];
        read_found = flag;
        reads++;
        if (test_open && !expect_match) begin
            // Nothing found yet, so the whole register reads as zero
            if (flag !== 1'b0) begin
                $display("[ERROR] test %0d: found expected 0x0, got 0x%0h", test_id, flag);
                errors++;
            end
            if (digest !== '0) begin
                $display("[ERROR] test %0d: found_digest expected 0x%032h, got 0x%032h",
                         test_id, digest_t'(0), digest);
                errors++;
            end
        end else if (test_open && flag === 1'b1) begin
            found_reads++;
            if (digest !== expect_digest) begin
                $display("[ERROR] test %0d: found_digest expected 0x%032h, got 0x%032h",
                         test_id, expect_digest, digest);
                errors++;
            end
            if (digest[$bits(digest_t)-1 -: FILTER_ZERO_BITS] !== '0) begin
                $display("[ERROR] test %0d: found_digest top bits expected 0x0, got 0x%0h",
                         test_id, digest[$bits(digest_t)-1 -: FILTER_ZERO_BITS]);
                errors++;
            end
            if (found_reads == 1) begin
                first_digest = digest;
            end else if (digest !== first_digest) begin  // Latched result must hold
                $display("[ERROR] test %0d: found_digest expected 0x%032h, got 0x%032h",
                         test_id, first_digest, digest);
                errors++;
            end
        end else if (test_open && found_reads > 0) begin
            $display("test %0d: found flag dropped after it had been set", test_id);
            errors++;
        end
    endtask

    // Reassemble each readback, found flag arrives first
    always @(posedge tck) begin
        if (capture_dr) begin
            nbits = 0;
        end else if (shift_dr && nbits < RESULT_BITS) begin
            shreg = {tdo, shreg[RESULT_BITS-1:1]};
            nbits++;
            if (nbits == RESULT_BITS) begin
                check_read(shreg);
            end
        end
    end

    always @(posedge test_active) begin
        reads = 0;
        found_reads = 0;
        errors = 0;
        test_open = 1'b1;
    end

    always @(negedge test_active) begin
        if (test_open) begin
            test_open = 1'b0;
            if (expect_match && found_reads < 2) begin
                $display("test %0d: found flag was not read back set twice", test_id);
                errors++;
            end
            if (!expect_match && reads == 0) begin
                $display("test %0d: no readback took place", test_id);
                errors++;
            end
            if (errors == 0) begin
                tests_passed++;
                $display("test %0d (%s): ok, %0d reads", test_id,
                         expect_match ? "key search" : "zero read", reads);
            end else begin
                tests_failed++;
                $display("test %0d (%s): failed with %0d errors", test_id,
                         expect_match ? "key search" : "zero read", errors);
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/user_logic_tb.sv
`timescale 1ns/1ps
`default_nettype none

module user_logic_tb import hash_search_pkg::*; ();

    logic tck;
    logic tms;
    logic tdi;
    logic test_logic_reset;
    logic ir_is_user;
    logic run_test_idle;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic tdo;

    logic test_active;
    logic expect_match;
    int test_id;
    digest_t expect_digest;
    logic read_found;
    int tests_passed;
    int tests_failed;

    // Expected suffix and digest per key come from the reference search
    string key_text [4] = '{"abcdef", "jtag", "pqrstuv", "secretkey123"};
    int exp_suffix [4];
    digest_t exp_digest [4];

    word_t sine_k [64];
    int model_failures = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    logic limit_ready = 1'b0;

    user_logic UUT (
        .tck              (tck),
        .tms              (tms),
        .tdi              (tdi),
        .test_logic_reset (test_logic_reset),
        .ir_is_user       (ir_is_user),
        .run_test_idle    (run_test_idle),
        .capture_dr       (capture_dr),
        .shift_dr         (shift_dr),
        .update_dr        (update_dr),
        .tdo              (tdo)
    );

    user_logic_checker result_checker (
        .tck           (tck),
        .capture_dr    (capture_dr),
        .shift_dr      (shift_dr),
        .tdo           (tdo),
        .test_active   (test_active),
        .expect_match  (expect_match),
        .test_id       (test_id),
        .expect_digest (expect_digest),
        .read_found    (read_found),
        .tests_passed  (tests_passed),
        .tests_failed  (tests_failed)
    );

    always #5 tck = ~tck;

    always @(posedge tck) begin
        cycle_count++;
        if (limit_ready && cycle_count >= cycle_limit) begin
            $display("timeout: no result found");
            $display("tests run: %0d passed, %0d failed", tests_passed, tests_failed + 1);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic word_t swap_bytes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic word_t rotate_left(input word_t w, input int s);
        return (w << s) | (w >> (32 - s));
    endfunction

    // Per-round rotate amounts from RFC 1321
    function automatic int rotate_amount(input int round);
        int col;
        col = round % 4;
        case (round / 16)
            0: return (col == 0) ? 7 : (col == 1) ? 12 : (col == 2) ? 17 : 22;
            1: return (col == 0) ? 5 : (col == 1) ? 9 : (col == 2) ? 14 : 20;
            2: return (col == 0) ? 4 : (col == 1) ? 11 : (col == 2) ? 16 : 23;
            default: return (col == 0) ? 6 : (col == 1) ? 10 : (col == 2) ? 15 : 21;
        endcase
    endfunction

    // floor(abs(sin(i+1)) * 2^32) built from two 16-bit halves
    task automatic fill_sine_table();
        real x;
        integer hi;
        integer lo;
        for (int i = 0; i < 64; i++) begin
            x = $sin(i + 1);
            if (x < 0.0) begin
                x = -x;
            end
            x = x * 4294967296.0;
            hi = $rtoi($floor(x / 65536.0));
            lo = $rtoi($floor(x - hi * 65536.0));
            sine_k[i] = {hi[15:0], lo[15:0]};
        end
    endtask

    // Single-block MD5 of a short text
    function automatic digest_t md5_of_text(input string text);
        byte_t blk [MD5_BLOCK_BYTES];
        word_t m [16];
        word_t h [4];
        word_t a;
        word_t b;
        word_t c;
        word_t d;
        word_t f;
        word_t tmp;
        int g;
        int n;
        longint unsigned bit_len;
        n = text.len();
        for (int i = 0; i < MD5_BLOCK_BYTES; i++) begin
            blk[i] = (i < n) ? text[i] : 8'h00;
        end
        blk[n] = 8'h80;
        bit_len = 8 * n;
        for (int i = 0; i < 8; i++) begin
            blk[MAX_MSG_BYTES + i] = bit_len[8*i +: 8];  // Little endian length
        end
        for (int i = 0; i < 16; i++) begin
            m[i] = {blk[4*i+3], blk[4*i+2], blk[4*i+1], blk[4*i]};
        end
        h = '{32'h67452301, 32'hefcdab89, 32'h98badcfe, 32'h10325476};
        a = h[0];
        b = h[1];
        c = h[2];
        d = h[3];
        for (int i = 0; i < 64; i++) begin
            case (i / 16)
                0: begin
                    f = (b & c) | (~b & d);
                    g = i;
                end
                1: begin
                    f = (d & b) | (~d & c);
                    g = (5 * i + 1) % 16;
                end
                2: begin
                    f = b ^ c ^ d;
                    g = (3 * i + 5) % 16;
                end
                default: begin
                    f = c ^ (b | ~d);
                    g = (7 * i) % 16;
                end
            endcase
            tmp = d;
            d = c;
            c = b;
            b = b + rotate_left(a + f + sine_k[i] + m[g], rotate_amount(i));
            a = tmp;
        end
        return {swap_bytes(a + h[0]), swap_bytes(b + h[1]),
                swap_bytes(c + h[2]), swap_bytes(d + h[3])};
    endfunction

    // Known answers from the RFC 1321 test suite
    function automatic bit model_matches_rfc();
        return md5_of_text("") == 128'hd41d8cd98f00b204e9800998ecf8427e
            && md5_of_text("abc") == 128'h900150983cd24fb0d6963f7d28e17f72
            && md5_of_text("message digest") == 128'hf96b697d7cb7938d525a2f31aaf161d0;
    endfunction

    // First decimal suffix whose digest starts with enough zero bits
    task automatic find_match(input string key, output int suffix, output digest_t digest);
        digest_t value;
        suffix = -1;
        digest = '0;
        for (int n = 0; n < 10000000 && suffix < 0; n++) begin
            value = md5_of_text($sformatf("%s%0d", key, n));
            if (value[127 -: FILTER_ZERO_BITS] == '0) begin
                suffix = n;
                digest = value;
            end
        end
    endtask

    task automatic apply_reset();
        test_logic_reset = 1'b1;
        repeat (2) @(negedge tck);
        test_logic_reset = 1'b0;
    endtask

    task automatic shift_bit(input logic b);
        tdi = b;
        shift_dr = 1'b1;
        @(negedge tck);
    endtask

    task automatic end_shift();
        shift_dr = 1'b0;
        tdi = 1'b0;
        update_dr = 1'b1;
        @(negedge tck);
        update_dr = 1'b0;
    endtask

    task automatic send_key(input string key);
        byte_t ch;
        capture_dr = 1'b1;
        @(negedge tck);
        capture_dr = 1'b0;
        for (int i = 0; i < UPSTREAM_BYPASS_BITS; i++) begin
            shift_bit(1'b0);  // Lands in the upstream BYPASS register
        end
        for (int i = 0; i <= key.len(); i++) begin
            ch = (i < key.len()) ? key[i] : 8'h0a;
            for (int j = 0; j < 8; j++) begin
                shift_bit(ch[j]);
            end
        end
        end_shift();
    endtask

    task automatic read_result();
        int gap;
        capture_dr = 1'b1;
        @(negedge tck);
        capture_dr = 1'b0;
        for (int i = 0; i < RESULT_BITS; i++) begin
            shift_bit(1'b0);
        end
        end_shift();
        gap = $urandom % 4;
        repeat (gap) @(negedge tck);
    endtask

    task automatic start_test(input int id, input logic match, input digest_t digest);
        test_id = id;
        expect_match = match;
        expect_digest = digest;
        test_active = 1'b1;
    endtask

    task automatic end_test();
        test_active = 1'b0;
        @(negedge tck);
    endtask

    task automatic finish_run();
        int failed;
        failed = tests_failed + model_failures;
        $display("tests run: %0d passed, %0d failed", tests_passed, failed);
        if (failed == 0 && tests_passed == $size(key_text) + 2) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    initial begin
        bit model_ok;
        tck = 1'b0;
        tms = 1'b0;
        tdi = 1'b0;
        test_logic_reset = 1'b1;
        ir_is_user = 1'b1;
        run_test_idle = 1'b0;
        capture_dr = 1'b0;
        shift_dr = 1'b0;
        update_dr = 1'b0;
        test_active = 1'b0;
        expect_match = 1'b0;
        test_id = 0;
        expect_digest = '0;
        void'($urandom(36728));

        fill_sine_table();
        model_ok = model_matches_rfc();
        for (int r = 0; r < $size(key_text); r++) begin
            find_match(key_text[r], exp_suffix[r], exp_digest[r]);
            $display("key \"%s\": suffix %0d, digest %032h", key_text[r], exp_suffix[r],
                     exp_digest[r]);
            cycle_limit += (exp_suffix[r] + 2) * 80;
        end
        cycle_limit += 2000;
        limit_ready = 1'b1;

        if (!model_ok) begin
            $display("reference MD5 model disagrees with the RFC 1321 test vectors");
            model_failures++;
            finish_run();
        end else begin
            @(negedge tck);
            start_test(1, 1'b0, '0);  // Nothing searched yet
            apply_reset();
            read_result();
            end_test();

            for (int r = 0; r < $size(key_text); r++) begin
                start_test(r + 2, 1'b1, exp_digest[r]);
                apply_reset();
                send_key(key_text[r]);
                do begin
                    read_result();
                end while (!read_found);
                read_result();  // Later digests must not replace the match
                end_test();
            end

            // Leaving the user instruction for one cycle
            start_test($size(key_text) + 2, 1'b0, '0);
            ir_is_user = 1'b0;
            @(negedge tck);
            ir_is_user = 1'b1;
            read_result();
            end_test();
            finish_run();
        end
    end

endmodule

`default_nettype wire

//--- user_logic.f
hw/hash_search_pkg.sv
hw/tap_decoder.sv
hw/line_decoder.sv
hw/ascii_counter.sv
hw/message_builder.sv
hw/md5_core.sv
hw/hash_filter.sv
hw/tap_encoder.sv
hw/user_logic.sv
verif/user_logic_checker.sv
verif/user_logic_tb.sv
